// ==== common/mini_mcu_pkg.sv ====
// Shared definitions for the mini MCU core
// OBI bus structs, instruction format, FSM states and fixed addresses
package mini_mcu_pkg;

    localparam logic [31:0] BOOT_ADDR  = 32'h0000_0180;
    localparam logic [31:0] IRQ_VECTOR = 32'h0000_0100;
    localparam int unsigned NUM_REGS   = 8;

    typedef struct packed {
        logic        req;
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } obi_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } obi_resp_t;

    // Unlisted codes execute as no-ops
    typedef enum logic [3:0] {
        OP_LI  = 4'h1,  // rd = sext(imm)
        OP_ADD = 4'h2,  // rd = rd + rs
        OP_XOR = 4'h3,  // rd = rd ^ rs
        OP_LW  = 4'h4,  // rd = mem[rs + sext(imm)]
        OP_SW  = 4'h5,  // mem[rs + sext(imm)] = rd
        OP_JMP = 4'h6,  // pc = zext(imm)
        OP_WFI = 4'h7   // sleep until any irq line is set
    } opcode_e;

    typedef enum logic [1:0] {
        ST_RUN,
        ST_MEM_WAIT,
        ST_SLEEP,
        ST_IRQ
    } exec_state_e;

    typedef struct packed {
        opcode_e     opcode;
        logic        rsvd_27;
        logic [2:0]  rd;
        logic        rsvd_23;
        logic [2:0]  rs;
        logic [3:0]  rsvd_19_16;
        logic [15:0] imm;
    } instr_t;

    typedef struct packed {
        instr_t      instr;
        logic [31:0] pc;
    } fetch_pkt_t;

    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } lsu_req_t;

endpackage

// ==== cpu/instr_fetch.sv ====
`timescale 1ns/100ps

// Instruction fetch unit
// OBI instruction master feeding a one-entry buffer, with redirect support
module instr_fetch (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    output mini_mcu_pkg::obi_req_t   instr_req_o,
    input  mini_mcu_pkg::obi_resp_t  instr_resp_i,
    output logic                     fetch_valid_o,
    output mini_mcu_pkg::fetch_pkt_t fetch_pkt_o,
    input  logic                     fetch_ready_i,
    input  logic                     redirect_i,
    input  logic [31:0]              redirect_addr_i
);

    logic [31:0]              pc_q;
    logic [31:0]              addr_q;
    logic                     req_q;
    logic                     outstanding_q;
    logic                     drop_q;
    logic                     buf_valid_q;
    mini_mcu_pkg::fetch_pkt_t buf_q;

    logic        rsp_arrives;
    logic        slot_free;
    logic        issue;
    logic [31:0] next_addr;

    assign rsp_arrives = outstanding_q && instr_resp_i.rvalid;
    // Buffer empty, being consumed or being flushed
    assign slot_free   = !buf_valid_q || fetch_ready_i || redirect_i;
    assign issue       = !req_q && !outstanding_q && slot_free;
    assign next_addr   = redirect_i ? redirect_addr_i : pc_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q          <= mini_mcu_pkg::BOOT_ADDR;
            req_q         <= 1'b0;
            outstanding_q <= 1'b0;
            drop_q        <= 1'b0;
            buf_valid_q   <= 1'b0;
        end else begin
            if (issue) begin
                req_q <= 1'b1;
                pc_q  <= next_addr + 32'd4;
            end else if (redirect_i) begin
                pc_q <= redirect_addr_i;
            end
            if (req_q && instr_resp_i.gnt) begin
                req_q         <= 1'b0;
                outstanding_q <= 1'b1;
            end
            if (rsp_arrives) begin
                outstanding_q <= 1'b0;
            end
            // Response of a transaction started before a redirect is stale
            if (rsp_arrives) begin
                drop_q <= 1'b0;
            end else if (redirect_i && (req_q || outstanding_q)) begin
                drop_q <= 1'b1;
            end
            if (redirect_i) begin
                buf_valid_q <= 1'b0;
            end else if (rsp_arrives && !drop_q) begin
                buf_valid_q <= 1'b1;
            end else if (fetch_ready_i) begin
                buf_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            addr_q <= next_addr;
        end
        if (rsp_arrives) begin
            buf_q.instr <= mini_mcu_pkg::instr_t'(instr_resp_i.rdata);
            buf_q.pc    <= addr_q;
        end
    end

    assign instr_req_o.req   = req_q;
    assign instr_req_o.we    = 1'b0;
    assign instr_req_o.be    = 4'b1111;
    assign instr_req_o.addr  = addr_q;
    assign instr_req_o.wdata = 32'h0;

    assign fetch_valid_o = buf_valid_q;
    assign fetch_pkt_o   = buf_q;

    // Pending request held until granted
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_req_o.req && !instr_resp_i.gnt |=> $stable(instr_req_o))
        else $error("instr_fetch: request changed before grant");

endmodule

// ==== cpu/decode_exec.sv ====
`timescale 1ns/100ps

// Decode and execute stage with an 8-entry register file
// Issues loads and stores to the LSU and handles sleep and interrupt wake-up
module decode_exec (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     fetch_valid_i,
    input  mini_mcu_pkg::fetch_pkt_t fetch_pkt_i,
    output logic                     fetch_ready_o,
    output logic                     redirect_o,
    output logic [31:0]              redirect_addr_o,
    output logic                     lsu_valid_o,
    output mini_mcu_pkg::lsu_req_t   lsu_req_o,
    input  logic                     lsu_ready_i,
    input  logic                     lsu_done_i,
    input  logic [31:0]              lsu_rdata_i,
    input  logic [31:0]              irq_i,
    output logic                     irq_ack_o,
    output logic [4:0]               irq_id_o,
    output logic                     core_sleep_o
);

    mini_mcu_pkg::exec_state_e state_q;
    logic [31:0]               rf_q [mini_mcu_pkg::NUM_REGS];
    logic                      lsu_sent_q;
    mini_mcu_pkg::lsu_req_t    lsu_req_q;
    logic [2:0]                load_rd_q;
    logic [4:0]                irq_id_q;

    mini_mcu_pkg::instr_t instr;
    logic                 accept;
    logic [31:0]          rs_val;
    logic [31:0]          rd_val;
    logic [31:0]          imm_sext;
    logic [4:0]           irq_lowest;

    assign instr    = fetch_pkt_i.instr;
    assign rs_val   = rf_q[instr.rs];
    assign rd_val   = rf_q[instr.rd];
    assign imm_sext = {{16{instr.imm[15]}}, instr.imm};

    // New instructions only while running
    assign fetch_ready_o = (state_q == mini_mcu_pkg::ST_RUN);
    assign accept        = fetch_valid_i && fetch_ready_o;

    always_comb begin
        redirect_o      = 1'b0;
        redirect_addr_o = mini_mcu_pkg::IRQ_VECTOR;
        if (state_q == mini_mcu_pkg::ST_IRQ) begin
            redirect_o = 1'b1;
        end else if (accept && instr.opcode == mini_mcu_pkg::OP_JMP) begin
            redirect_o      = 1'b1;
            redirect_addr_o = {16'h0, instr.imm};
        end
    end

    // Lowest pending line wins
    always_comb begin
        irq_lowest = 5'd0;
        for (int i = 31; i >= 0; i--) begin
            if (irq_i[i]) begin
                irq_lowest = 5'(i);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= mini_mcu_pkg::ST_RUN;
            lsu_sent_q <= 1'b0;
            irq_id_q   <= 5'd0;
            for (int r = 0; r < mini_mcu_pkg::NUM_REGS; r++) begin
                rf_q[r] <= 32'h0;
            end
        end else begin
            case (state_q)
                mini_mcu_pkg::ST_RUN: begin
                    if (accept) begin
                        case (instr.opcode)
                            mini_mcu_pkg::OP_LI:  rf_q[instr.rd] <= imm_sext;
                            mini_mcu_pkg::OP_ADD: rf_q[instr.rd] <= rd_val + rs_val;
                            mini_mcu_pkg::OP_XOR: rf_q[instr.rd] <= rd_val ^ rs_val;
                            mini_mcu_pkg::OP_LW, mini_mcu_pkg::OP_SW: begin
                                state_q    <= mini_mcu_pkg::ST_MEM_WAIT;
                                lsu_sent_q <= 1'b0;
                            end
                            mini_mcu_pkg::OP_WFI: state_q <= mini_mcu_pkg::ST_SLEEP;
                            default: ;
                        endcase
                    end
                end
                mini_mcu_pkg::ST_MEM_WAIT: begin
                    if (lsu_valid_o && lsu_ready_i) begin
                        lsu_sent_q <= 1'b1;
                    end
                    if (lsu_done_i) begin
                        state_q <= mini_mcu_pkg::ST_RUN;
                        if (!lsu_req_q.we) begin
                            rf_q[load_rd_q] <= lsu_rdata_i;
                        end
                    end
                end
                mini_mcu_pkg::ST_SLEEP: begin
                    if (|irq_i) begin
                        state_q  <= mini_mcu_pkg::ST_IRQ;
                        irq_id_q <= irq_lowest;
                    end
                end
                default: state_q <= mini_mcu_pkg::ST_RUN;
            endcase
        end
    end

    // Memory request captured at acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            lsu_req_q.we    <= (instr.opcode == mini_mcu_pkg::OP_SW);
            lsu_req_q.addr  <= rs_val + imm_sext;
            lsu_req_q.wdata <= rd_val;
            load_rd_q       <= instr.rd;
        end
    end

    assign lsu_valid_o  = (state_q == mini_mcu_pkg::ST_MEM_WAIT) && !lsu_sent_q;
    assign lsu_req_o    = lsu_req_q;
    assign irq_ack_o    = (state_q == mini_mcu_pkg::ST_IRQ);
    assign irq_id_o     = irq_id_q;
    assign core_sleep_o = (state_q == mini_mcu_pkg::ST_SLEEP);

    // Acknowledged id is the lowest line pending in the last sleep cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        irq_ack_o |-> ((($past(irq_i) >> irq_id_o) & 32'h1) == 32'h1)
                      && (($past(irq_i) & ((32'h1 << irq_id_o) - 32'h1)) == 32'h0))
        else $error("decode_exec: irq_id_o is not the lowest pending line");

endmodule

// ==== cpu/load_store_unit.sv ====
`timescale 1ns/100ps

// Load/store unit
// Turns execute requests into single OBI data transactions
module load_store_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    lsu_valid_i,
    input  mini_mcu_pkg::lsu_req_t  lsu_req_i,
    output logic                    lsu_ready_o,
    output logic                    lsu_done_o,
    output logic [31:0]             lsu_rdata_o,
    output mini_mcu_pkg::obi_req_t  data_req_o,
    input  mini_mcu_pkg::obi_resp_t data_resp_i
);

    logic                   req_q;
    logic                   outstanding_q;
    logic                   done_q;
    mini_mcu_pkg::lsu_req_t hold_q;
    logic [31:0]            rdata_q;

    logic accept;
    logic rsp_arrives;

    // One transaction at a time, from acceptance to done
    assign lsu_ready_o = !req_q && !outstanding_q && !done_q;
    assign accept      = lsu_valid_i && lsu_ready_o;
    assign rsp_arrives = outstanding_q && data_resp_i.rvalid;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_q         <= 1'b0;
            outstanding_q <= 1'b0;
            done_q        <= 1'b0;
        end else begin
            done_q <= rsp_arrives;
            if (accept) begin
                req_q <= 1'b1;
            end else if (req_q && data_resp_i.gnt) begin
                req_q         <= 1'b0;
                outstanding_q <= 1'b1;
            end
            if (rsp_arrives) begin
                outstanding_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            hold_q <= lsu_req_i;
        end
        if (rsp_arrives) begin
            rdata_q <= data_resp_i.rdata;
        end
    end

    assign data_req_o.req   = req_q;
    assign data_req_o.we    = hold_q.we;
    assign data_req_o.be    = 4'b1111;
    assign data_req_o.addr  = hold_q.addr;
    assign data_req_o.wdata = hold_q.wdata;

    assign lsu_done_o  = done_q;
    assign lsu_rdata_o = rdata_q;

    // rvalid only answers a granted request
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_resp_i.rvalid |-> outstanding_q)
        else $error("load_store_unit: rvalid with no transaction pending");

endmodule

// ==== cpu/cpu_subsystem.sv ====
`timescale 1ns/100ps

// Core wrapper: fetch, execute and load/store unit behind two OBI ports
module cpu_subsystem (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    output mini_mcu_pkg::obi_req_t  instr_req_o,
    input  mini_mcu_pkg::obi_resp_t instr_resp_i,
    output mini_mcu_pkg::obi_req_t  data_req_o,
    input  mini_mcu_pkg::obi_resp_t data_resp_i,
    input  logic [31:0]             irq_i,
    output logic                    irq_ack_o,
    output logic [4:0]              irq_id_o,
    output logic                    core_sleep_o
);

    logic                     fetch_valid;
    logic                     fetch_ready;
    mini_mcu_pkg::fetch_pkt_t fetch_pkt;
    logic                     redirect;
    logic [31:0]              redirect_addr;
    logic                     lsu_valid;
    logic                     lsu_ready;
    mini_mcu_pkg::lsu_req_t   lsu_req;
    logic                     lsu_done;
    logic [31:0]              lsu_rdata;

    instr_fetch instr_fetch_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .instr_req_o    (instr_req_o),
        .instr_resp_i   (instr_resp_i),
        .fetch_valid_o  (fetch_valid),
        .fetch_pkt_o    (fetch_pkt),
        .fetch_ready_i  (fetch_ready),
        .redirect_i     (redirect),
        .redirect_addr_i(redirect_addr)
    );

    decode_exec decode_exec_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .fetch_valid_i  (fetch_valid),
        .fetch_pkt_i    (fetch_pkt),
        .fetch_ready_o  (fetch_ready),
        .redirect_o     (redirect),
        .redirect_addr_o(redirect_addr),
        .lsu_valid_o    (lsu_valid),
        .lsu_req_o      (lsu_req),
        .lsu_ready_i    (lsu_ready),
        .lsu_done_i     (lsu_done),
        .lsu_rdata_i    (lsu_rdata),
        .irq_i          (irq_i),
        .irq_ack_o      (irq_ack_o),
        .irq_id_o       (irq_id_o),
        .core_sleep_o   (core_sleep_o)
    );

    load_store_unit load_store_unit_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .lsu_valid_i(lsu_valid),
        .lsu_req_i  (lsu_req),
        .lsu_ready_o(lsu_ready),
        .lsu_done_o (lsu_done),
        .lsu_rdata_o(lsu_rdata),
        .data_req_o (data_req_o),
        .data_resp_i(data_resp_i)
    );

endmodule

// ==== verif/tb_iss_model.svh ====
// Instruction-set reference model for the core testbench
// Runs the program on private copies and logs every store in order
`ifndef TB_ISS_MODEL_SVH
`define TB_ISS_MODEL_SVH

logic [31:0] iss_imem [1024];
logic [31:0] iss_dmem [64];
logic [31:0] iss_regs [8];
logic [31:0] log_addr [$];
logic [31:0] log_data [$];

// Executes from start_pc until WFI or a jump to itself
task automatic iss_run(input logic [31:0] start_pc);
    mini_mcu_pkg::instr_t ins;
    logic [31:0]          pc;
    logic [31:0]          next_pc;
    logic [31:0]          imm_s;
    logic [31:0]          ea;
    int                   steps;
    bit                   done;
    pc    = start_pc;
    steps = 0;
    done  = 1'b0;
    while (!done) begin
        ins     = mini_mcu_pkg::instr_t'(iss_imem[pc[11:2]]);
        imm_s   = {{16{ins.imm[15]}}, ins.imm};
        ea      = iss_regs[ins.rs] + imm_s;
        next_pc = pc + 32'd4;
        if ((ins.opcode == mini_mcu_pkg::OP_LW || ins.opcode == mini_mcu_pkg::OP_SW)
            && ea[31:8] != DATA_BASE[31:8]) begin
            abort_run("reference model access outside the data window");
        end
        case (ins.opcode)
            mini_mcu_pkg::OP_LI:  iss_regs[ins.rd] = imm_s;
            mini_mcu_pkg::OP_ADD: iss_regs[ins.rd] = iss_regs[ins.rd] + iss_regs[ins.rs];
            mini_mcu_pkg::OP_XOR: iss_regs[ins.rd] = iss_regs[ins.rd] ^ iss_regs[ins.rs];
            mini_mcu_pkg::OP_LW:  iss_regs[ins.rd] = iss_dmem[ea[7:2]];
            mini_mcu_pkg::OP_SW: begin
                iss_dmem[ea[7:2]] = iss_regs[ins.rd];
                log_addr.push_back(ea);
                log_data.push_back(iss_regs[ins.rd]);
            end
            mini_mcu_pkg::OP_JMP: begin
                next_pc = {16'h0, ins.imm};
                done    = (next_pc == pc);
            end
            mini_mcu_pkg::OP_WFI: done = 1'b1;
            default: ;
        endcase
        pc = next_pc;
        steps++;
        if (steps > 4096) begin
            abort_run("reference model never reached WFI or a self jump");
        end
    end
endtask

`endif

// ==== verif/tb_cpu_subsystem.sv ====
`timescale 1ns/100ps

// Testbench for the mini MCU core
// Random program checked against an ISS, OBI responders with random stalls, WFI wake-up
module tb_cpu_subsystem;

    localparam logic [31:0] DATA_BASE = 32'h0000_1000;
    localparam int          MAIN_LEN  = 40;
    localparam int          HNDL_LEN  = 16;
    localparam logic [2:0]  BASE_REG  = 3'd7;
    localparam int          TIMEOUT   = 5000;

    logic                    clk = 1'b0;
    logic                    rst_n = 1'b0;
    mini_mcu_pkg::obi_req_t  instr_req;
    mini_mcu_pkg::obi_resp_t instr_resp = '0;
    mini_mcu_pkg::obi_req_t  data_req;
    mini_mcu_pkg::obi_resp_t data_resp = '0;
    logic [31:0]             irq = 32'h0;
    logic                    irq_ack;
    logic [4:0]              irq_id;
    logic                    core_sleep;

    logic [31:0] imem [1024];
    logic [31:0] dmem [64];

    // Monitor state
    bit          prev_req = 1'b0;
    bit          prev_sleep = 1'b0;
    bit          first_seen = 1'b0;
    bit          ack_seen = 1'b0;
    bit          vec_seen = 1'b0;
    logic [31:0] first_addr = 32'h0;
    logic [31:0] vec_addr = 32'h0;
    int          ack_count = 0;
    int          store_idx = 0;

    always #5 clk = ~clk;

    cpu_subsystem cpu_subsystem_inst (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .instr_req_o (instr_req),
        .instr_resp_i(instr_resp),
        .data_req_o  (data_req),
        .data_resp_i (data_resp),
        .irq_i       (irq),
        .irq_ack_o   (irq_ack),
        .irq_id_o    (irq_id),
        .core_sleep_o(core_sleep)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    `include "tb_iss_model.svh"

    function automatic logic [31:0] make_instr(input mini_mcu_pkg::opcode_e op,
            input logic [2:0] rd, input logic [2:0] rs, input logic [15:0] imm);
        mini_mcu_pkg::instr_t w;
        w        = '0;
        w.opcode = op;
        w.rd     = rd;
        w.rs     = rs;
        w.imm    = imm;
        return w;
    endfunction

    // r7 holds the data window base and is never a destination
    function automatic logic [31:0] random_instr();
        logic [2:0]  dst;
        logic [2:0]  src;
        logic [15:0] off;
        logic [31:0] w;
        dst = 3'($urandom_range(0, 6));
        src = 3'($urandom_range(0, 7));
        off = 16'($urandom_range(0, 63) * 4);
        case ($urandom_range(0, 4))
            0: w = make_instr(mini_mcu_pkg::OP_LI, dst, 3'd0, 16'($urandom()));
            1: w = make_instr(mini_mcu_pkg::OP_ADD, dst, src, 16'h0);
            2: w = make_instr(mini_mcu_pkg::OP_XOR, dst, src, 16'h0);
            3: w = make_instr(mini_mcu_pkg::OP_LW, dst, BASE_REG, off);
            default: w = make_instr(mini_mcu_pkg::OP_SW, src, BASE_REG, off);
        endcase
        return w;
    endfunction

    task automatic build_program();
        int unsigned boot_w;
        int unsigned vec_w;
        boot_w = mini_mcu_pkg::BOOT_ADDR >> 2;
        vec_w  = mini_mcu_pkg::IRQ_VECTOR >> 2;
        // Unused words are no-ops carrying their own address
        for (int i = 0; i < 1024; i++) begin
            imem[10'(i)] = {16'h0, 16'(i * 4)};
        end
        for (int i = 0; i < 64; i++) begin
            dmem[6'(i)] = $urandom();
        end
        imem[10'(boot_w)] = make_instr(mini_mcu_pkg::OP_LI, BASE_REG, 3'd0, DATA_BASE[15:0]);
        for (int i = 1; i < MAIN_LEN - 1; i++) begin
            imem[10'(boot_w + i)] = random_instr();
        end
        imem[10'(boot_w + MAIN_LEN - 1)] = make_instr(mini_mcu_pkg::OP_WFI, 3'd0, 3'd0, 16'h0);
        for (int i = 0; i < HNDL_LEN - 1; i++) begin
            imem[10'(vec_w + i)] = random_instr();
        end
        // Handler ends spinning on itself
        imem[10'(vec_w + HNDL_LEN - 1)] = make_instr(mini_mcu_pkg::OP_JMP, 3'd0, 3'd0,
            16'(mini_mcu_pkg::IRQ_VECTOR + (HNDL_LEN - 1) * 4));
        iss_imem = imem;
        iss_dmem = dmem;
        for (int r = 0; r < 8; r++) begin
            iss_regs[3'(r)] = 32'h0;
        end
        iss_run(mini_mcu_pkg::BOOT_ADDR);
        iss_run(mini_mcu_pkg::IRQ_VECTOR);
    endtask

    task automatic set_resp(input bit is_data, input logic gnt, input logic rvalid,
                            input logic [31:0] rdata);
        mini_mcu_pkg::obi_resp_t rsp;
        rsp.gnt    = gnt;
        rsp.rvalid = rvalid;
        rsp.rdata  = rdata;
        if (is_data) begin
            data_resp = rsp;
        end else begin
            instr_resp = rsp;
        end
    endtask

    // Instruction port is read-only with all byte lanes enabled
    task automatic read_instr(input mini_mcu_pkg::obi_req_t req, output logic [31:0] word);
        word = 32'h0;
        if (req.addr[31:12] != 20'h0 || req.addr[1:0] != 2'b00) begin
            abort_run($sformatf("instruction fetch from bad address %h", req.addr));
        end
        check_value("instr_we", 32'h0, 32'(req.we));
        check_value("instr_be", 32'hf, 32'(req.be));
        check_value("instr_wdata", 32'h0, req.wdata);
        word = imem[req.addr[11:2]];
    endtask

    // Stores are compared with the ISS log when granted
    task automatic access_data(input mini_mcu_pkg::obi_req_t req, output logic [31:0] rdata);
        rdata = 32'h0;
        if (req.addr[31:8] != DATA_BASE[31:8] || req.addr[1:0] != 2'b00) begin
            abort_run($sformatf("data access at %h outside the data window", req.addr));
        end
        check_value("data_be", 32'hf, 32'(req.be));
        if (req.we) begin
            if (store_idx >= log_addr.size()) begin
                abort_run("store issued beyond the end of the reference log");
            end
            check_value("store_addr", log_addr[store_idx], req.addr);
            check_value("store_data", log_data[store_idx], req.wdata);
            store_idx++;
            dmem[req.addr[7:2]] = req.wdata;
        end else begin
            rdata = dmem[req.addr[7:2]];
        end
    endtask

    // OBI memory with 0 to 3 cycles of gnt and rvalid delay
    task automatic serve_port(input bit is_data);
        mini_mcu_pkg::obi_req_t req;
        logic [31:0]            rdata;
        int unsigned            delay;
        forever begin
            @(posedge clk);
            #1;
            set_resp(is_data, 1'b0, 1'b0, 32'h0);
            req = is_data ? data_req : instr_req;
            if (rst_n && req.req) begin
                delay = $urandom_range(0, 3);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                req = is_data ? data_req : instr_req;
                if (is_data) begin
                    access_data(req, rdata);
                end else begin
                    read_instr(req, rdata);
                end
                set_resp(is_data, 1'b1, 1'b0, 32'h0);
                delay = $urandom_range(0, 3);
                @(posedge clk);
                #1;
                set_resp(is_data, 1'b0, 1'b0, 32'h0);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                set_resp(is_data, 1'b0, 1'b1, rdata);
            end
        end
    endtask

    initial serve_port(1'b0);
    initial serve_port(1'b1);

    // Watches instruction requests and interrupt acks between edges
    always @(negedge clk) begin
        if (rst_n) begin
            if (instr_req.req && !prev_req) begin
                if (!first_seen) begin
                    first_seen = 1'b1;
                    first_addr = instr_req.addr;
                end
                if (core_sleep && prev_sleep) begin
                    abort_run("instruction request issued while the core sleeps");
                end
                if (ack_seen && !vec_seen) begin
                    vec_seen = 1'b1;
                    vec_addr = instr_req.addr;
                end
            end
            if (irq_ack) begin
                ack_count++;
                ack_seen = 1'b1;
            end
            prev_req   = instr_req.req;
            prev_sleep = core_sleep;
        end
    end

    task automatic check_idle_outputs(input string name);
        check_value({name, "_irq_ack"}, 32'h0, 32'(irq_ack));
        check_value({name, "_sleep"}, 32'h0, 32'(core_sleep));
        check_value({name, "_data_req"}, 32'h0, 32'(data_req.req));
        check_value({name, "_irq_id"}, 32'h0, 32'(irq_id));
    endtask

    initial begin
        logic [31:0] irq_pat;
        logic [31:0] shifted;
        logic [4:0]  exp_id;
        int          n;
        void'($urandom(32'hd01c5160));
        build_program();
        repeat (5) begin
            @(posedge clk);
            #1;
            check_idle_outputs("reset_held");
            check_value("reset_instr_req", 32'h0, 32'(instr_req.req));
        end
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_idle_outputs("after_reset");
        // First fetch goes out on the first edge after release
        check_value("after_reset_instr_req", 32'h1, 32'(instr_req.req));
        n = 0;
        while (!first_seen) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for the first instruction request");
        end
        check_value("boot_addr", mini_mcu_pkg::BOOT_ADDR, first_addr);
        n = 0;
        while (!core_sleep) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for the core to sleep after WFI");
        end
        repeat (20) begin
            @(posedge clk);
            #1;
        end
        irq_pat = $urandom() << $urandom_range(0, 31);
        if (irq_pat == 32'h0) begin
            irq_pat = 32'h8000_0000;
        end
        shifted = irq_pat;
        exp_id  = 5'd0;
        while (!shifted[0]) begin
            shifted = shifted >> 1;
            exp_id++;
        end
        irq = irq_pat;
        n = 0;
        while (!irq_ack) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for the interrupt acknowledge");
        end
        check_value("irq_id", 32'(exp_id), 32'(irq_id));
        check_value("sleep_at_ack", 32'h0, 32'(core_sleep));
        irq = 32'h0;
        n = 0;
        while (!vec_seen) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for the fetch after wake-up");
        end
        check_value("wake_fetch_addr", mini_mcu_pkg::IRQ_VECTOR, vec_addr);
        n = 0;
        while (store_idx < log_addr.size()) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for all expected stores");
        end
        // Let the self jump spin to catch duplicated stores
        repeat (100) begin
            @(posedge clk);
            #1;
        end
        check_value("irq_ack_count", 32'd1, 32'(ack_count));
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verif
common/mini_mcu_pkg.sv
cpu/instr_fetch.sv
cpu/decode_exec.sv
cpu/load_store_unit.sv
cpu/cpu_subsystem.sv
verif/tb_cpu_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the core and its testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_cpu_subsystem -f vlog.f \
    --Mdir obj_dir -o tb_cpu_subsystem
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_subsystem > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^All checks passed$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
